// ==== design/fv_pkg.sv ====
// Feature-vector buffer package
`default_nettype none

package fv_pkg;

    // buffer geometry
    localparam int NUM_BANKS      = 4;
    localparam int FV_WIDTH       = 32;
    localparam int WORDS_PER_FV   = 4;
    localparam int NODES_PER_BANK = 16;

    localparam int NODE_W  = 4;
    localparam int WORD_W  = 2;
    localparam int ADDR_W  = NODE_W + WORD_W;
    localparam int FVNUM_W = 5;

    // edge PE side
    localparam int NUM_EDGE_PE = 8;
    localparam int TAG_W       = 3;

    // request edge to first output word
    localparam int READ_LAT = 2;

    // address is {node_id, word}, so node * WORDS_PER_FV + word
    localparam int SRAM_DEPTH = NODES_PER_BANK * WORDS_PER_FV;
    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(WORDS_PER_FV - 1);

    // one beat from an edge PE, rd_wr high for a write
    typedef struct packed {
        logic                valid;
        logic [TAG_W-1:0]    pe_tag;
        logic                rd_wr;
        logic [NODE_W-1:0]   node_id;
        logic [FV_WIDTH-1:0] data;
        logic                wr_sos;
        logic                wr_eos;
    } fv_req_t;

    // SRAM port, enables active low
    typedef struct packed {
        logic                cen_n;
        logic                wen_n;
        logic [ADDR_W-1:0]   addr;
        logic [FV_WIDTH-1:0] data;
    } fv_sram_req_t;

    // tagged read word back to an edge PE
    typedef struct packed {
        logic                valid;
        logic                sos;
        logic                eos;
        logic [TAG_W-1:0]    pe_tag;
        logic [FV_WIDTH-1:0] data;
    } fv_rd_resp_t;

    // replay word to a small FV buffer
    typedef struct packed {
        logic                valid;
        logic                sos;
        logic                eos;
        logic [ADDR_W-1:0]   addr;
        logic [FV_WIDTH-1:0] data;
    } fv_stream_t;

endpackage

`default_nettype wire

// ==== design/fv_sram.sv ====
// Single-port feature-vector SRAM
`timescale 1ns/10ps
`default_nettype none

module fv_sram (
    input  logic                          clk,
    input  fv_pkg::fv_sram_req_t          req,
    output logic [fv_pkg::FV_WIDTH-1:0]   q
);

    logic [fv_pkg::FV_WIDTH-1:0] mem [fv_pkg::SRAM_DEPTH];

    // one access per cycle, read data registered
    always_ff @(posedge clk) begin
        if (!req.cen_n) begin
            if (!req.wen_n) begin
                mem[req.addr] <= req.data;
            end else begin
                q <= mem[req.addr];
            end
        end
    end

    // selected bank must see a clean address
    a_addr_known: assert property (
        @(posedge clk) !req.cen_n |-> !$isunknown(req.addr)
    ) else $error("fv_sram: unknown address with chip enable low");

endmodule

`default_nettype wire

// ==== design/fv_read_sequencer.sv ====
// Read and replay address sequencer
`timescale 1ns/10ps
`default_nettype none

module fv_read_sequencer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic                          replay,
    input  logic [fv_pkg::NODE_W-1:0]     node_id,
    input  logic [fv_pkg::TAG_W-1:0]      pe_tag,
    input  logic [fv_pkg::FVNUM_W-1:0]    fv_num,
    output logic [fv_pkg::ADDR_W-1:0]     rd_addr,
    output logic                          issue,
    output logic                          busy,
    output fv_pkg::fv_rd_resp_t           mark,
    output logic [fv_pkg::ADDR_W-1:0]     mark_addr,
    output logic                          mark_replay
);

    logic [fv_pkg::NODE_W-1:0] node_cnt;
    logic [fv_pkg::NODE_W-1:0] node_last;
    logic [fv_pkg::WORD_W-1:0] word_cnt;
    logic [fv_pkg::TAG_W-1:0]  tag_q;
    logic                      replay_q;
    logic                      last_word;
    logic                      last_node;
    logic                      empty_replay;
    logic                      mark_vld;
    logic                      mark_sos;
    logic                      mark_eos;
    logic [fv_pkg::TAG_W-1:0]  mark_tag;

    // replay of zero vectors never goes busy
    assign empty_replay = replay && (fv_num == '0);
    assign last_word    = (word_cnt == fv_pkg::LAST_WORD);
    assign last_node    = (node_cnt == node_last);

    assign issue   = busy;
    assign rd_addr = {node_cnt, word_cnt};

    // node and word counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            node_cnt <= '0;
            word_cnt <= '0;
        end else if (start && !empty_replay) begin
            busy     <= 1'b1;
            node_cnt <= replay ? '0 : node_id;
            word_cnt <= '0;
        end else if (busy) begin
            word_cnt <= word_cnt + fv_pkg::WORD_W'(1);
            if (last_word) begin
                if (last_node) begin
                    busy <= 1'b0;
                end else begin
                    node_cnt <= node_cnt + fv_pkg::NODE_W'(1);
                end
            end
        end
    end

    // request context held for the whole run
    always_ff @(posedge clk) begin
        if (start) begin
            node_last <= replay ? fv_pkg::NODE_W'(fv_num - fv_pkg::FVNUM_W'(1)) : node_id;
            tag_q     <= pe_tag;
            replay_q  <= replay;
        end
    end

    // markers line up with the registered SRAM word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mark_vld <= 1'b0;
            mark_sos <= 1'b0;
            mark_eos <= 1'b0;
        end else begin
            mark_vld <= issue;
            mark_sos <= issue && (word_cnt == '0);
            mark_eos <= issue && last_word;
        end
    end

    always_ff @(posedge clk) begin
        mark_tag    <= tag_q;
        mark_addr   <= rd_addr;
        mark_replay <= replay_q;
    end

    always_comb begin
        mark        = '0;
        mark.valid  = mark_vld;
        mark.sos    = mark_sos;
        mark.eos    = mark_eos;
        mark.pe_tag = mark_tag;
    end

    // the controller only launches an idle sequencer
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!arst_n) start |-> !busy
    ) else $error("fv_read_sequencer: start while busy");

endmodule

`default_nettype wire

// ==== design/fv_bank_cntl.sv ====
// Feature-vector bank controller
`timescale 1ns/10ps
`default_nettype none

module fv_bank_cntl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  fv_pkg::fv_req_t               req,
    input  logic                          stream_begin,
    input  logic [fv_pkg::FVNUM_W-1:0]    fv_num,
    input  logic [fv_pkg::FV_WIDTH-1:0]   sram_q,
    output fv_pkg::fv_sram_req_t          sram_req,
    output fv_pkg::fv_rd_resp_t           rd_resp,
    output fv_pkg::fv_stream_t            stream_out,
    output logic                          available
);

    fv_pkg::fv_req_t           req_q;
    logic                      req_vld;
    logic                      stream_q;
    logic                      wr_beat;
    logic                      rd_launch;
    logic                      wr_open;
    logic [fv_pkg::WORD_W-1:0] wr_idx;
    logic [fv_pkg::WORD_W-1:0] wr_word;

    logic                      seq_start;
    logic                      seq_issue;
    logic                      seq_busy;
    logic [fv_pkg::ADDR_W-1:0] seq_addr;
    fv_pkg::fv_rd_resp_t       mark;
    logic [fv_pkg::ADDR_W-1:0] mark_addr;
    logic                      mark_replay;

    // beats are taken only while the bank is free
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_vld  <= 1'b0;
            stream_q <= 1'b0;
        end else begin
            req_vld  <= req.valid && available;
            stream_q <= stream_begin && available;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req;
    end

    assign wr_beat   = req_vld && req_q.rd_wr;
    assign rd_launch = req_vld && !req_q.rd_wr;

    // word index within the open write stream
    assign wr_word = req_q.wr_sos ? '0 : wr_idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx  <= '0;
            wr_open <= 1'b0;
        end else if (wr_beat) begin
            wr_idx  <= wr_word + fv_pkg::WORD_W'(1);
            wr_open <= !req_q.wr_eos;
        end
    end

    // replay wins if both land together
    assign seq_start = rd_launch || stream_q;
    assign available = !seq_busy && !seq_start;

    fv_read_sequencer i_fv_read_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (seq_start),
        .replay      (stream_q),
        .node_id     (req_q.node_id),
        .pe_tag      (req_q.pe_tag),
        .fv_num      (fv_num),
        .rd_addr     (seq_addr),
        .issue       (seq_issue),
        .busy        (seq_busy),
        .mark        (mark),
        .mark_addr   (mark_addr),
        .mark_replay (mark_replay)
    );

    // SRAM port, sequencer reads first
    always_comb begin
        sram_req.cen_n = 1'b1;
        sram_req.wen_n = 1'b1;
        sram_req.addr  = seq_addr;
        sram_req.data  = req_q.data;
        if (seq_issue) begin
            sram_req.cen_n = 1'b0;
        end else if (wr_beat) begin
            sram_req.cen_n = 1'b0;
            sram_req.wen_n = 1'b0;
            sram_req.addr  = {req_q.node_id, wr_word};
        end
    end

    // steer the SRAM word by the run's mode
    always_comb begin
        rd_resp        = mark;
        rd_resp.valid  = mark.valid && !mark_replay;
        rd_resp.sos    = mark.sos && !mark_replay;
        rd_resp.eos    = mark.eos && !mark_replay;
        rd_resp.data   = sram_q;

        stream_out.valid = mark.valid && mark_replay;
        stream_out.sos   = mark.sos && mark_replay;
        stream_out.eos   = mark.eos && mark_replay;
        stream_out.addr  = mark_addr;
        stream_out.data  = sram_q;
    end

    // end marker needs an earlier start marker
    a_eos_open: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wr_beat && req_q.wr_eos && !req_q.wr_sos) |-> wr_open
    ) else $error("fv_bank_cntl: wr_eos without open write stream");

    // a burst opens on word 0 of a vector
    a_burst_sos: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(mark.valid) |-> mark.sos
    ) else $error("fv_bank_cntl: output burst starts without sos");

endmodule

`default_nettype wire

// ==== design/fv_buffer.sv ====
// Big feature-vector buffer top
`timescale 1ns/10ps
`default_nettype none

module fv_buffer (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic [fv_pkg::FVNUM_W-1:0]                      fv_num,
    input  logic                                            stream_begin,
    input  fv_pkg::fv_req_t     [fv_pkg::NUM_BANKS-1:0]     req,
    output fv_pkg::fv_rd_resp_t [fv_pkg::NUM_BANKS-1:0]     rd_resp,
    output fv_pkg::fv_stream_t  [fv_pkg::NUM_BANKS-1:0]     stream_out,
    output logic                                            available
);

    fv_pkg::fv_sram_req_t [fv_pkg::NUM_BANKS-1:0]                      sram_req;
    logic                 [fv_pkg::NUM_BANKS-1:0][fv_pkg::FV_WIDTH-1:0] sram_q;
    logic                 [fv_pkg::NUM_BANKS-1:0]                      bank_available;

    // ping buffer only, one controller and SRAM per bank
    for (genvar b = 0; b < fv_pkg::NUM_BANKS; b++) begin : g_bank

        fv_bank_cntl i_fv_bank_cntl (
            .clk          (clk),
            .arst_n       (arst_n),
            .req          (req[b]),
            .stream_begin (stream_begin),
            .fv_num       (fv_num),
            .sram_q       (sram_q[b]),
            .sram_req     (sram_req[b]),
            .rd_resp      (rd_resp[b]),
            .stream_out   (stream_out[b]),
            .available    (bank_available[b])
        );

        fv_sram i_fv_sram (
            .clk (clk),
            .req (sram_req[b]),
            .q   (sram_q[b])
        );

    end

    // whole buffer free only when every bank is
    assign available = &bank_available;

endmodule

`default_nettype wire

// ==== tests/fv_buffer_tb_tasks.svh ====
// Feature-vector buffer test tasks

// all stimulus starts 1 ns after a rising edge
task automatic tick();
    @(posedge clk);
    #1;
endtask

task automatic idle_inputs();
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        req[b] = '0;
    end
    stream_begin = 1'b0;
endtask

task automatic report_test(input string name, input int start);
    if (error_count == start) begin
        tests_passed++;
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: FAILED with %0d errors", name, error_count - start);
    end
endtask

// tag and data only matter on a valid word
task automatic compare_rd_resp(input int bank, input fv_pkg::fv_rd_resp_t got,
                               input fv_pkg::fv_rd_resp_t exp, input string what);
    if (got.valid !== exp.valid || got.sos !== exp.sos || got.eos !== exp.eos ||
        (exp.valid && (got.pe_tag !== exp.pe_tag || got.data !== exp.data))) begin
        error_count++;
        $display("** Error at %0t: bank %0d rd_resp %s, got %h expected %h",
                 $time, bank, what, got, exp);
    end
endtask

task automatic compare_stream(input int bank, input fv_pkg::fv_stream_t got,
                              input fv_pkg::fv_stream_t exp, input string what);
    if (got.valid !== exp.valid || got.sos !== exp.sos || got.eos !== exp.eos ||
        (exp.valid && (got.addr !== exp.addr || got.data !== exp.data))) begin
        error_count++;
        $display("** Error at %0t: bank %0d stream_out %s, got %h expected %h",
                 $time, bank, what, got, exp);
    end
endtask

task automatic compare_available(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("** Error at %0t: available %s, got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic random_words(output logic [fv_pkg::WORDS_PER_FV-1:0][fv_pkg::FV_WIDTH-1:0] w);
    for (int k = 0; k < fv_pkg::WORDS_PER_FV; k++) begin
        w[k] = $random(seed);
    end
endtask

task automatic write_fv(input int bank, input logic [fv_pkg::NODE_W-1:0] node,
                        input logic [fv_pkg::WORDS_PER_FV-1:0][fv_pkg::FV_WIDTH-1:0] w);
    for (int k = 0; k < fv_pkg::WORDS_PER_FV; k++) begin
        req[bank]         = '0;
        req[bank].valid   = 1'b1;
        req[bank].rd_wr   = 1'b1;
        req[bank].node_id = node;
        req[bank].data    = w[k];
        req[bank].wr_sos  = (k == 0);
        req[bank].wr_eos  = (k == fv_pkg::WORDS_PER_FV - 1);
        ref_mem[bank][{node, fv_pkg::WORD_W'(k)}] = w[k];
        tick();
        compare_available(available, 1'b1, "during write");
    end
    req[bank] = '0;
endtask

// tagged reads on the banks set in mask, all launched together
task automatic read_banks(input logic [fv_pkg::NUM_BANKS-1:0] mask,
                          input logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::NODE_W-1:0] nodes,
                          input logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::TAG_W-1:0] tags);
    int                  word [fv_pkg::NUM_BANKS];
    int                  cycles;
    logic                all_done;
    fv_pkg::fv_rd_resp_t exp;
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        word[b] = mask[b] ? 0 : fv_pkg::WORDS_PER_FV;
        if (mask[b]) begin
            req[b].valid   = 1'b1;
            req[b].node_id = nodes[b];
            req[b].pe_tag  = tags[b];
        end
    end
    tick();
    idle_inputs();
    compare_available(available, 1'b0, "after read accepted");
    cycles = 0;
    all_done = 1'b0;
    while (!all_done && cycles < RESP_TIMEOUT) begin
        tick();
        cycles++;
        all_done = 1'b1;
        for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
            compare_stream(b, stream_out[b], '0, "idle during read");
            exp = '0;
            if (word[b] < fv_pkg::WORDS_PER_FV && cycles == fv_pkg::READ_LAT + word[b]) begin
                exp.valid  = 1'b1;
                exp.sos    = (word[b] == 0);
                exp.eos    = (word[b] == fv_pkg::WORDS_PER_FV - 1);
                exp.pe_tag = tags[b];
                exp.data   = ref_mem[b][{nodes[b], fv_pkg::WORD_W'(word[b])}];
                if (word[b] == 0) begin
                    compare_available(available, 1'b0, "during read");
                end
                word[b]++;
            end
            compare_rd_resp(b, rd_resp[b], exp, "read word");
            if (word[b] < fv_pkg::WORDS_PER_FV) begin
                all_done = 1'b0;
            end
        end
    end
    if (!all_done) begin
        error_count++;
        $display("read response missing: words did not arrive within %0d cycles", RESP_TIMEOUT);
    end
    tick();
    compare_available(available, 1'b1, "after read");
endtask

task automatic read_fv(input int bank, input logic [fv_pkg::NODE_W-1:0] node,
                       input logic [fv_pkg::TAG_W-1:0] tag);
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::NODE_W-1:0] nodes;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::TAG_W-1:0]  tags;
    nodes       = '0;
    tags        = '0;
    nodes[bank] = node;
    tags[bank]  = tag;
    read_banks(fv_pkg::NUM_BANKS'(1) << bank, nodes, tags);
endtask

// word i of every bank is due READ_LAT + i cycles after the pulse
task automatic replay(input int n);
    int                        total;
    int                        cycles;
    int                        idx;
    logic [fv_pkg::ADDR_W-1:0] addr;
    fv_pkg::fv_stream_t        exp;
    total        = n * fv_pkg::WORDS_PER_FV;
    fv_num       = fv_pkg::FVNUM_W'(n);
    stream_begin = 1'b1;
    tick();
    stream_begin = 1'b0;
    cycles = 0;
    while (cycles < RESP_TIMEOUT && (total == 0 || cycles < fv_pkg::READ_LAT + total)) begin
        tick();
        cycles++;
        idx = cycles - fv_pkg::READ_LAT;
        for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
            compare_rd_resp(b, rd_resp[b], '0, "idle during replay");
            exp = '0;
            if (idx >= 0 && idx < total) begin
                addr      = fv_pkg::ADDR_W'((idx / fv_pkg::WORDS_PER_FV) * fv_pkg::WORDS_PER_FV
                                            + idx % fv_pkg::WORDS_PER_FV);
                exp.valid = 1'b1;
                exp.sos   = (idx % fv_pkg::WORDS_PER_FV == 0);
                exp.eos   = (idx % fv_pkg::WORDS_PER_FV == fv_pkg::WORDS_PER_FV - 1);
                exp.addr  = addr;
                exp.data  = ref_mem[b][addr];
            end
            compare_stream(b, stream_out[b], exp, "replay word");
        end
    end
    tick();
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        compare_stream(b, stream_out[b], '0, "after replay");
    end
    compare_available(available, 1'b1, "after replay");
endtask

task automatic test_reset_state();
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        compare_rd_resp(b, rd_resp[b], '0, "after reset");
        compare_stream(b, stream_out[b], '0, "after reset");
    end
    compare_available(available, 1'b1, "after reset");
endtask

task automatic test_write_read();
    logic [fv_pkg::WORDS_PER_FV-1:0][fv_pkg::FV_WIDTH-1:0] w;
    random_words(w);
    write_fv(0, 4'd5, w);
    read_fv(0, 4'd5, 3'd3);
endtask

task automatic test_all_banks();
    logic [fv_pkg::WORDS_PER_FV-1:0][fv_pkg::FV_WIDTH-1:0] w;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::NODE_W-1:0]      nodes;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::TAG_W-1:0]       tags;
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        nodes[b] = fv_pkg::NODE_W'(b + 2);
        tags[b]  = fv_pkg::TAG_W'(b + 4);
        random_words(w);
        write_fv(b, nodes[b], w);
    end
    read_banks('1, nodes, tags);
endtask

task automatic test_replay();
    logic [fv_pkg::WORDS_PER_FV-1:0][fv_pkg::FV_WIDTH-1:0] w;
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        for (int n = 0; n < 3; n++) begin
            random_words(w);
            write_fv(b, fv_pkg::NODE_W'(n), w);
        end
    end
    replay(3);
endtask

// few node slots so that some writes overwrite earlier ones
task automatic test_random();
    logic [fv_pkg::WORDS_PER_FV-1:0][fv_pkg::FV_WIDTH-1:0] w;
    logic [7:0]                                            written [fv_pkg::NUM_BANKS];
    int                                                    bank;
    int                                                    node;
    int                                                    first_bank;
    int                                                    first_node;
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        written[b] = '0;
    end
    first_bank = 0;
    first_node = 0;
    for (int i = 0; i < 16; i++) begin
        bank = $random(seed) & 3;
        node = $random(seed) & 7;
        // last write lands on the first slot again
        if (i == 0) begin
            first_bank = bank;
            first_node = node;
        end else if (i == 15) begin
            bank = first_bank;
            node = first_node;
        end
        random_words(w);
        write_fv(bank, fv_pkg::NODE_W'(node), w);
        written[bank][node] = 1'b1;
    end
    for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
        for (int n = 0; n < 8; n++) begin
            if (written[b][n]) begin
                read_fv(b, fv_pkg::NODE_W'(n), fv_pkg::TAG_W'(n));
            end
        end
    end
endtask

// ==== tests/fv_buffer_tb.sv ====
// Feature-vector buffer testbench
`timescale 1ns/10ps
`default_nettype none

module fv_buffer_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESP_TIMEOUT = 20;

    // cycle budget of each test, for the watchdog
    localparam int BUDGET_RESET  = 10;
    localparam int BUDGET_WR_RD  = 30;
    localparam int BUDGET_ALL    = 40;
    localparam int BUDGET_REPLAY = 100;
    localparam int BUDGET_EMPTY  = 30;
    localparam int BUDGET_RANDOM = 420;
    localparam int TOTAL_CYCLES  = BUDGET_RESET + BUDGET_WR_RD + BUDGET_ALL
                                 + BUDGET_REPLAY + BUDGET_EMPTY + BUDGET_RANDOM;

    logic                                         clk;
    logic                                         arst_n;
    logic [fv_pkg::FVNUM_W-1:0]                   fv_num;
    logic                                         stream_begin;
    fv_pkg::fv_req_t     [fv_pkg::NUM_BANKS-1:0]  req;
    fv_pkg::fv_rd_resp_t [fv_pkg::NUM_BANKS-1:0]  rd_resp;
    fv_pkg::fv_stream_t  [fv_pkg::NUM_BANKS-1:0]  stream_out;
    logic                                         available;

    // reference contents of every bank
    logic [fv_pkg::FV_WIDTH-1:0] ref_mem [fv_pkg::NUM_BANKS][fv_pkg::SRAM_DEPTH];

    integer seed;
    int     error_count;
    int     tests_passed;
    int     tests_failed;

    `include "fv_buffer_tb_tasks.svh"

    fv_buffer i_fv_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .fv_num       (fv_num),
        .stream_begin (stream_begin),
        .req          (req),
        .rd_resp      (rd_resp),
        .stream_out   (stream_out),
        .available    (available)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("watchdog: simulation did not finish within its cycle budget");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int start;
        seed         = 32'hf0e7;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        fv_num       = '0;
        idle_inputs();
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        tick();

        start = error_count;
        test_reset_state();
        report_test("reset state", start);

        start = error_count;
        test_write_read();
        report_test("write then tagged read", start);

        start = error_count;
        test_all_banks();
        report_test("parallel reads on all banks", start);

        start = error_count;
        test_replay();
        report_test("replay of three vectors", start);

        start = error_count;
        replay(0);
        report_test("replay of zero vectors", start);

        start = error_count;
        test_random();
        report_test("random overwrite and readback", start);

        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/fv_pkg.sv
design/fv_sram.sv
design/fv_read_sequencer.sv
design/fv_bank_cntl.sv
design/fv_buffer.sv
+incdir+tests
tests/fv_buffer_tb.sv

// ==== Makefile ====
# Verilator build and run of the feature-vector buffer testbench

TOP := fv_buffer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -o $(TOP)_sim

run: build
	@out="$$(./obj_dir/$(TOP)_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
